// ==== hdl/cpu_alu.sv ====
module cpu_alu
    import cpu_pkg::*;
(
    input  opcode_e     op,
    input  logic        high,
    input  logic [15:0] imm,
    input  word_t       a_data,
    input  word_t       b_data,
    input  logic        a_flag,
    input  logic        b_flag,
    input  word_t       mem_data,
    output word_t       result,
    output logic        zero,
    output logic        wr_en,
    output logic        take_jump,
    output word_t       target
);

    always_comb
    begin
        result    = b_data;
        wr_en     = 1'b1;
        take_jump = 1'b0;
        case (op)
            OP_ADD:
                result = a_data + b_data;
            OP_SUB:
                result = a_data - b_data;
            OP_AND:
                result = a_data & b_data;
            OP_OR:
                result = a_data | b_data;
            OP_XOR:
                result = a_data ^ b_data;
            OP_LDI:
            begin
                if (high)
                    result = {imm, 16'h0000};
                else
                    result = word_t'(imm);
            end
            OP_LOAD:
                result = mem_data;
            OP_JUMP:
            begin
                wr_en     = 1'b0;
                take_jump = 1'b1;
            end
            OP_JFLAG:
            begin
                wr_en     = 1'b0;
                take_jump = a_flag;
            end
            // nop, store and undefined codes leave the banks alone
            default:
                wr_en = 1'b0;
        endcase
    end

    // non-writing ops pass B and its flag through
    assign zero = wr_en ? (result == '0) : b_flag;

    // jumps are absolute within the low 64K words
    assign target = word_t'(imm);

endmodule

// ==== hdl/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and address width
`define CPU_WORD_BITS 32

// general registers with one flag beside each
`define CPU_NUM_REGS 8

// first fetch address out of reset
`define CPU_RESET_PC 0

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_BITS-1:0] word_t;

    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

    // one instruction walks all three states in order
    typedef enum logic [1:0]
    {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        UPDATE  = 2'd2
    } cpu_state_e;

    typedef enum logic [5:0]
    {
        OP_NOP   = 6'd0,
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LDI   = 6'd6,
        OP_STORE = 6'd7,
        OP_LOAD  = 6'd8,
        OP_JUMP  = 6'd9,
        OP_JFLAG = 6'd10
    } opcode_e;

    // msb first so op lands in bits 5..0
    typedef struct packed
    {
        logic [15:0] imm;
        logic        high;
        reg_idx_t    dst;
        reg_idx_t    src_b;
        reg_idx_t    src_a;
        opcode_e     op;
    } instr_t;

endpackage

// ==== hdl/cpu_sequencer.sv ====
`include "cpu_macros.svh"

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  word_t       data_in,
    input  logic        take_jump,
    input  word_t       target,
    input  word_t       a_value,
    output opcode_e     op,
    output reg_idx_t    src_a,
    output reg_idx_t    src_b,
    output reg_idx_t    dst,
    output logic        high,
    output logic [15:0] imm,
    output logic        exec_stb,
    output word_t       address,
    output logic        rw
);

    cpu_state_e state;
    cpu_state_e next_state;
    word_t      pc;
    instr_t     ir;
    logic       mem_op;

    always_comb
    begin
        case (state)
            FETCH:   next_state = EXECUTE;
            EXECUTE: next_state = UPDATE;
            default: next_state = FETCH;
        endcase
    end

    // pc only moves at the end of UPDATE
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= FETCH;
            pc    <= word_t'(`CPU_RESET_PC);
        end
        else
        begin
            state <= next_state;
            if (state == UPDATE)
            begin
                pc <= take_jump ? target : pc + word_t'(1);
            end
        end
    end

    // memory answers in the same cycle, so capture on the FETCH edge
    always_ff @(posedge clock)
    begin
        if (state == FETCH)
        begin
            ir <= instr_t'(data_in);
        end
    end

    assign op    = ir.op;
    assign src_a = ir.src_a;
    assign src_b = ir.src_b;
    assign dst   = ir.dst;
    assign high  = ir.high;
    assign imm   = ir.imm;

    assign exec_stb = (state == EXECUTE);

    assign mem_op = (ir.op == OP_STORE) || (ir.op == OP_LOAD);

    // loads and stores address through register A while executing
    always_comb
    begin
        if (state == EXECUTE && mem_op)
            address = a_value;
        else
            address = pc;
    end

    assign rw = !(state == EXECUTE && ir.op == OP_STORE);

endmodule

// ==== hdl/cpu_top.sv ====
module cpu_top
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  rst,
    input  word_t data_in,
    output word_t data_out,
    output word_t address,
    output logic  rw
);

    opcode_e     op;
    reg_idx_t    src_a;
    reg_idx_t    src_b;
    reg_idx_t    dst;
    logic        high;
    logic [15:0] imm;
    logic        exec_stb;
    word_t       rd_a_data;
    word_t       rd_b_data;
    logic        a_flag;
    logic        b_flag;
    word_t       result;
    logic        zero;
    logic        wr_en;
    logic        take_jump;
    word_t       target;
    logic        bank_wr;

    // both banks commit once, at the end of EXECUTE
    assign bank_wr = exec_stb & wr_en;

    // store data always comes from register B
    assign data_out = rd_b_data;

    cpu_sequencer u_seq (
        .clock     (clock),
        .rst       (rst),
        .data_in   (data_in),
        .take_jump (take_jump),
        .target    (target),
        .a_value   (rd_a_data),
        .op        (op),
        .src_a     (src_a),
        .src_b     (src_b),
        .dst       (dst),
        .high      (high),
        .imm       (imm),
        .exec_stb  (exec_stb),
        .address   (address),
        .rw        (rw)
    );

    register_bank #(
        .payload_t   (word_t),
        .reset_value ('0)
    ) u_regs (
        .clock     (clock),
        .rst       (rst),
        .wr_en     (bank_wr),
        .wr_idx    (dst),
        .wr_data   (result),
        .rd_a_idx  (src_a),
        .rd_b_idx  (src_b),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

    register_bank #(
        .payload_t   (logic),
        .reset_value (1'b0)
    ) u_flags (
        .clock     (clock),
        .rst       (rst),
        .wr_en     (bank_wr),
        .wr_idx    (dst),
        .wr_data   (zero),
        .rd_a_idx  (src_a),
        .rd_b_idx  (src_b),
        .rd_a_data (a_flag),
        .rd_b_data (b_flag)
    );

    cpu_alu u_alu (
        .op        (op),
        .high      (high),
        .imm       (imm),
        .a_data    (rd_a_data),
        .b_data    (rd_b_data),
        .a_flag    (a_flag),
        .b_flag    (b_flag),
        .mem_data  (data_in),
        .result    (result),
        .zero      (zero),
        .wr_en     (wr_en),
        .take_jump (take_jump),
        .target    (target)
    );

endmodule

// ==== hdl/register_bank.sv ====
`include "cpu_macros.svh"

module register_bank
    import cpu_pkg::*;
#(
    parameter type      payload_t   = word_t,
    parameter payload_t reset_value = '0
)
(
    input  logic     clock,
    input  logic     rst,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  payload_t wr_data,
    input  reg_idx_t rd_a_idx,
    input  reg_idx_t rd_b_idx,
    output payload_t rd_a_data,
    output payload_t rd_b_data
);

    payload_t entries [`CPU_NUM_REGS];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                entries[i] <= reset_value;
            end
        end
        else if (wr_en)
        begin
            entries[wr_idx] <= wr_data;
        end
    end

    // no bypass so a write shows up on the cycle after
    assign rd_a_data = entries[rd_a_idx];
    assign rd_b_data = entries[rd_b_idx];

endmodule

// ==== project.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/register_bank.sv
hdl/cpu_alu.sv
hdl/cpu_sequencer.sv
hdl/cpu_top.sv
test/cpu_props.sv
test/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module cpu_tb -o sim_cpu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_cpu > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1
grep -qF "*** TEST PASSED ***" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0

// ==== test/cpu_props.sv ====
`include "cpu_macros.svh"

module cpu_props
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  word_t       address,
    input  logic        rw,
    input  logic        exec_stb,
    input  opcode_e     op,
    input  logic [15:0] imm,
    input  logic        a_flag,
    input  word_t       a_value
);

    logic jump_expected;

    // a jump, or a flag jump whose source flag is set
    assign jump_expected = (op == OP_JUMP) || (op == OP_JFLAG && a_flag);

    // first fetch out of reset
    reset_fetch: assert property (@(posedge clock)
        $fell(rst) |-> (address == word_t'(`CPU_RESET_PC) && rw))
        else $error("first fetch after reset is not a read of the reset address");

    // one instruction every three cycles
    exec_period: assert property (@(posedge clock) disable iff (rst)
        exec_stb |-> ##3 exec_stb)
        else $error("execute strobe did not repeat after three cycles");

    // sequential flow including untaken flag jumps
    fetch_step: assert property (@(posedge clock) disable iff (rst)
        (exec_stb && !jump_expected) |-> ##2 (address == $past(address, 3) + word_t'(1)))
        else $error("next fetch address is not the previous one plus one");

    jump_lands: assert property (@(posedge clock) disable iff (rst)
        (exec_stb && jump_expected) |-> ##2 (address == word_t'($past(imm, 2))))
        else $error("fetch after a taken jump is not at the immediate");

    // writes happen only while a store executes
    write_only_in_store: assert property (@(posedge clock) disable iff (rst)
        !rw |-> (exec_stb && op == OP_STORE))
        else $error("memory write outside the execute cycle of a store");

    store_writes: assert property (@(posedge clock) disable iff (rst)
        (exec_stb && op == OP_STORE) |-> (!rw && address == a_value))
        else $error("store did not write to the address held in register A");

endmodule

bind cpu_top cpu_props u_props (
    .clock    (clock),
    .rst      (rst),
    .address  (address),
    .rw       (rw),
    .exec_stb (exec_stb),
    .op       (op),
    .imm      (imm),
    .a_flag   (a_flag),
    .a_value  (rd_a_data)
);

// ==== test/cpu_tb.sv ====
module cpu_tb
    import cpu_pkg::*;
();

    localparam int         MEM_WORDS     = 64;
    localparam int         PROGRAM_WORDS = 49;
    localparam int         CYCLE_LIMIT   = (PROGRAM_WORDS + 20) * 3;
    localparam logic [5:0] HALT_ADDR     = 6'd63;
    localparam word_t      POISON        = 32'h0000_dead;

    // operands the program builds with LDI in its low and high forms
    localparam word_t OPND_LO = 32'h0000_5a5a;
    localparam word_t OPND_HI = {16'h0ff0, 16'h0000};

    logic   clock;
    logic   rst;
    word_t  data_in;
    word_t  data_out;
    word_t  address;
    logic   rw;
    word_t  mem [MEM_WORDS];
    word_t  rand_words [4];
    integer seed;
    int     cycles = 0;

    cpu_top u_dut (
        .clock    (clock),
        .rst      (rst),
        .data_in  (data_in),
        .data_out (data_out),
        .address  (address),
        .rw       (rw)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // memory answers in the same cycle
    always_comb data_in = mem[address[5:0]];

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic string store_test_name(input logic [5:0] addr);
        case (addr)
            6'd50: return "ldi_high";
            6'd51: return "ldi_low";
            6'd52: return "add";
            6'd53: return "sub";
            6'd54: return "and";
            6'd55: return "or";
            6'd56: return "xor";
            6'd57: return "load_sum";
            6'd58: return "jflag_fall";
            6'd63: return "halt";
            default: return "";
        endcase
    endfunction

    task automatic check_store(input logic [5:0] addr, input word_t actual);
        word_t expected;
        string name;
        name = store_test_name(addr);
        case (addr)
            6'd50: expected = OPND_HI;
            6'd51: expected = OPND_LO;
            6'd52: expected = OPND_LO + OPND_HI;
            6'd53: expected = OPND_HI - OPND_LO;
            6'd54: expected = (OPND_HI - OPND_LO) & OPND_LO;
            6'd55: expected = OPND_LO | OPND_HI;
            6'd56: expected = OPND_LO ^ (OPND_HI - OPND_LO);
            6'd57: expected = rand_words[0] + rand_words[1] + rand_words[2] + rand_words[3];
            6'd58: expected = OPND_LO;
            6'd63: expected = OPND_HI;
            default: expected = '0;
        endcase
        if (actual == POISON)
        begin
            $display("poison code stored at address %0d, a flag jump went the wrong way", addr);
            stop_with_failure();
        end
        else if (name == "")
        begin
            $display("store to address %0d, which the program never writes", addr);
            stop_with_failure();
        end
        else if (actual !== expected)
        begin
            $display("** Error test %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
        else if (addr == HALT_ADDR)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    endtask

    initial
    begin
        seed = 32'h118d_a008;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i[5:0]] = {16'hf11f, 10'h000, i[5:0]};
        end
        $readmemh("test/program.hex", mem, 0, PROGRAM_WORDS - 1);
        rand_words[0] = $random(seed);
        rand_words[1] = $random(seed);
        rand_words[2] = $random(seed);
        rand_words[3] = $random(seed);
        rst = 1'b1;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    end

    // load data area gets its random words while reset is held
    always @(posedge clock)
    begin
        if (rst)
        begin
            mem[6'd40] <= rand_words[0];
            mem[6'd41] <= rand_words[1];
            mem[6'd42] <= rand_words[2];
            mem[6'd43] <= rand_words[3];
        end
        else if (!rw)
        begin
            mem[address[5:0]] <= data_out;
            check_store(address[5:0], data_out);
        end
    end

    always @(posedge clock)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, no store to the halt address after %0d cycles", cycles);
            stop_with_failure();
        end
    end

endmodule

// ==== test/program.hex ====
// one 32-bit instruction word per line, from address 0
// words 40 to 43 are the load data area, filled at run time
// operands, store pointer starts at 50, r7 holds the step of one
5a5a1006
0ff0a006
00324006
00017006
// stores of both LDI forms, pointer step after each store
00000507
00004f01
00000307
00004f01
// add, sub, and, or, xor
00003441
00000707
00004f01
00003282
00000707
00004f01
000052c3
00000b07
00004f01
00005444
00000b07
00004f01
00005645
00000b07
00004f01
// four loads from 40..43 summed into r5
00286006
00005188
00006f81
00003188
00005741
00006f81
00003188
00005741
00006f81
00003188
00005741
00000b07
00004f01
// untaken flag jump, then a zero result and a taken flag jump over the data area
002c004a
dead5006
00003242
002d00ca
00000000
00000000
00000000
00000000
// poison store, must be skipped
00000b07
00000307
003f4006
00000507
00300009
